//--- verilog/vmul_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector multiply unit constants
// Widths, queue depths and multiplier pipeline length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef VMUL_CONSTS_SVH
`define VMUL_CONSTS_SVH

// Operand and result word width
`define ELEN 64
// Instruction queue entries
`define VINSN_DEPTH 4
// Result queue entries
`define RESULT_DEPTH 2
// Default multiplier register stages
`define MUL_PIPE_REGS 2
// Number of instruction ids, one done bit each
`define NR_VINSN 8
// Words per vector register
`define VREG_WORDS 8

`endif

//--- verilog/rvv_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector ISA types
// Element widths, multiply operations and the data word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vmul_consts.svh"

package rvv_isa_pkg;

  // Selected element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    ew8  = 2'd0,
    ew16 = 2'd1,
    ew32 = 2'd2,
    ew64 = 2'd3
  } vew_e;

  // Integer multiply operations
  typedef enum logic [2:0] {
    op_vmul    = 3'd0,
    op_vmulh   = 3'd1,
    op_vmulhu  = 3'd2,
    op_vmulhsu = 3'd3,
    op_vmacc   = 3'd4,
    op_vnmsac  = 3'd5
  } mul_op_e;

  typedef logic [`ELEN-1:0]   elen_t;
  // One enable per byte of a data word
  typedef logic [`ELEN/8-1:0] strb_t;

endpackage

//--- verilog/vmul_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector multiply unit types
// Instruction, tag and result formats plus element counting helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vmul_consts.svh"

package vmul_pkg;

  typedef logic [2:0] vid_t;
  // Element count, up to 64
  typedef logic [6:0] vlen_t;
  typedef logic [4:0] vreg_t;
  // Register file word address
  typedef logic [7:0] vaddr_t;

  typedef struct packed {
    vid_t                 id;
    rvv_isa_pkg::mul_op_e op;
    rvv_isa_pkg::vew_e    vsew;
    vlen_t                vl;
    vreg_t                vd;
    // Set means unmasked
    logic                 vm;
    logic                 use_scalar;
    logic                 use_vs1;
    logic                 use_vs2;
    logic                 use_vd;
    rvv_isa_pkg::elen_t   scalar;
  } vinsn_t;

  typedef struct packed {
    vid_t               id;
    vaddr_t             addr;
    rvv_isa_pkg::strb_t be;
  } tag_t;

  typedef struct packed {
    tag_t               tag;
    rvv_isa_pkg::elen_t wdata;
  } result_t;

  // Elements packed into one data word
  function automatic vlen_t elems_per_word(rvv_isa_pkg::vew_e ew);
    return vlen_t'(`ELEN / 8) >> ew;
  endfunction

  // Elements left after one more word, clamped at zero
  function automatic vlen_t elems_left(vlen_t rem, rvv_isa_pkg::vew_e ew);
    vlen_t epw;
    epw = elems_per_word(ew);
    return (rem > epw) ? rem - epw : '0;
  endfunction

endpackage

//--- verilog/vinsn_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector instruction queue
// Holds in-flight instructions across the accept, issue, processing and
// commit phases, issues operand words and raises done per instruction id
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vmul_consts.svh"

module vinsn_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vmul_pkg::vinsn_t     vinsn_i,
  input  logic                 vinsn_valid_i,
  output logic                 vinsn_ready_o,
  input  logic [2:0]           operand_valid_i,
  output logic [2:0]           operand_ready_o,
  input  logic                 mask_valid_i,
  output logic                 mask_ready_o,
  output logic                 issue_valid_o,
  input  logic                 issue_ready_i,
  output vmul_pkg::vinsn_t     issue_insn_o,
  output vmul_pkg::vinsn_t     proc_insn_o,
  output logic                 proc_valid_o,
  input  logic                 proc_done_i,
  input  logic                 commit_i,
  output logic [`NR_VINSN-1:0] done_o
);
  import vmul_pkg::*;

  localparam int unsigned PtrW = $clog2(`VINSN_DEPTH);

  // Depth is a power of two, so pointers wrap by overflow
  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  vinsn_t mem_q [`VINSN_DEPTH];

  ptr_t accept_ptr_q;
  ptr_t issue_ptr_q;
  ptr_t proc_ptr_q;
  ptr_t commit_ptr_q;
  // Instructions not yet fully issued, processed and committed
  cnt_t issue_cnt_q;
  cnt_t proc_cnt_q;
  cnt_t commit_cnt_q;
  // Elements left of the head instruction in issue and in commit
  vlen_t issue_rem_q;
  vlen_t issue_rem_d;
  vlen_t commit_rem_q;
  vlen_t commit_rem_d;

  vinsn_t     commit_insn;
  logic       accept;
  logic       issue_fire;
  logic       issue_last;
  logic       commit_last;
  logic [2:0] used_ops;

  // Full once every slot waits for its commit
  assign vinsn_ready_o = commit_cnt_q != cnt_t'(`VINSN_DEPTH);
  assign accept        = vinsn_valid_i && vinsn_ready_o;

  assign issue_insn_o = mem_q[issue_ptr_q];
  assign proc_insn_o  = mem_q[proc_ptr_q];
  assign commit_insn  = mem_q[commit_ptr_q];
  assign proc_valid_o = proc_cnt_q != '0;

  // Operand slots are vd, vs2, vs1 from the top
  assign used_ops = {issue_insn_o.use_vd, issue_insn_o.use_vs2, issue_insn_o.use_vs1};

  // Word goes out once every used operand and the mask are present
  assign issue_valid_o = (issue_cnt_q != '0) && ((operand_valid_i & used_ops) == used_ops)
                         && (mask_valid_i || issue_insn_o.vm);
  assign issue_fire      = issue_valid_o && issue_ready_i;
  assign operand_ready_o = issue_fire ? used_ops : 3'b000;
  assign mask_ready_o    = issue_fire && !issue_insn_o.vm;

  assign issue_last  = issue_fire && (elems_left(issue_rem_q, issue_insn_o.vsew) == '0);
  assign commit_last = commit_i && (elems_left(commit_rem_q, commit_insn.vsew) == '0);

  // One-hot done in the grant cycle of the last word
  always_comb begin
    done_o = '0;
    if (commit_last) begin
      done_o[commit_insn.id] = 1'b1;
    end
  end

  always_comb begin
    issue_rem_d = issue_rem_q;
    if (issue_fire) begin
      issue_rem_d = elems_left(issue_rem_q, issue_insn_o.vsew);
    end
    // Next queued instruction takes over the issue head
    if (issue_last && issue_cnt_q > cnt_t'(1)) begin
      issue_rem_d = mem_q[ptr_t'(issue_ptr_q + 1'b1)].vl;
    end
    // New instruction lands on an empty issue phase
    if (accept && (issue_cnt_q - cnt_t'(issue_last)) == '0) begin
      issue_rem_d = vinsn_i.vl;
    end
  end

  always_comb begin
    commit_rem_d = commit_rem_q;
    if (commit_i) begin
      commit_rem_d = elems_left(commit_rem_q, commit_insn.vsew);
    end
    if (commit_last && commit_cnt_q > cnt_t'(1)) begin
      commit_rem_d = mem_q[ptr_t'(commit_ptr_q + 1'b1)].vl;
    end
    if (accept && (commit_cnt_q - cnt_t'(commit_last)) == '0) begin
      commit_rem_d = vinsn_i.vl;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q <= '0;
      issue_ptr_q  <= '0;
      proc_ptr_q   <= '0;
      commit_ptr_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
    end else begin
      accept_ptr_q <= accept_ptr_q + ptr_t'(accept);
      issue_ptr_q  <= issue_ptr_q + ptr_t'(issue_last);
      proc_ptr_q   <= proc_ptr_q + ptr_t'(proc_done_i);
      commit_ptr_q <= commit_ptr_q + ptr_t'(commit_last);
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_last);
      proc_cnt_q   <= proc_cnt_q + cnt_t'(accept) - cnt_t'(proc_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_last);
      issue_rem_q  <= issue_rem_d;
      commit_rem_q <= commit_rem_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_ptr_q] <= vinsn_i;
    end
  end

  // Accepted entry lands on the free slot behind the held ones
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> accept_ptr_q == ptr_t'(commit_ptr_q + commit_cnt_q)
               && proc_cnt_q < cnt_t'(`VINSN_DEPTH));

  // Result queue only commits words of a held instruction
  a_commit_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> commit_cnt_q != '0);

endmodule

//--- verilog/simd_mul.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SIMD multiplier
// Per-lane multiply, multiply-high and multiply-accumulate on a 64-bit
// word, followed by an elastic register pipeline carrying result and mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vmul_consts.svh"

module simd_mul #(
  parameter int unsigned NumPipeRegs = `MUL_PIPE_REGS
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  vmul_pkg::vinsn_t         insn_i,
  input  rvv_isa_pkg::elen_t [2:0] operand_i,
  input  rvv_isa_pkg::strb_t       mask_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output logic                     valid_o,
  output rvv_isa_pkg::elen_t       result_o,
  output rvv_isa_pkg::strb_t       mask_o,
  input  logic                     ready_i
);
  import rvv_isa_pkg::*;

  // One lane of width w; inputs hold the lane in their low bits
  function automatic elen_t lane_op(elen_t a, elen_t b, elen_t c, int unsigned w,
                                    mul_op_e op, logic sgn_a, logic sgn_b);
    elen_t               lmask;
    logic                ext_a;
    logic                ext_b;
    logic signed [64:0]  xa;
    logic signed [64:0]  xb;
    logic signed [129:0] prod;
    elen_t               lo;
    elen_t               hi;
    // Shift by 64 yields zero, so the mask becomes all ones
    lmask = (64'd1 << w) - 64'd1;
    ext_a = sgn_a & a[w-1];
    ext_b = sgn_b & b[w-1];
    // Sign or zero extend each lane to 65 bits
    xa    = {ext_a, (a & lmask) | ({`ELEN{ext_a}} & ~lmask)};
    xb    = {ext_b, (b & lmask) | ({`ELEN{ext_b}} & ~lmask)};
    prod  = xa * xb;
    lo    = elen_t'(prod) & lmask;
    hi    = elen_t'(prod >>> w) & lmask;
    case (op)
      op_vmulh, op_vmulhu, op_vmulhsu: lane_op = hi;
      op_vmacc:  lane_op = (c + lo) & lmask;
      op_vnmsac: lane_op = (c - lo) & lmask;
      default:   lane_op = lo;
    endcase
  endfunction

  elen_t       scalar_rep;
  elen_t       opa;
  elen_t       res;
  int unsigned lane_w;
  int unsigned nr_lanes;
  logic        sgn_a;
  logic        sgn_b;

  // Scalar copied into every lane of the selected width
  always_comb begin
    case (insn_i.vsew)
      ew8:     scalar_rep = {8{insn_i.scalar[7:0]}};
      ew16:    scalar_rep = {4{insn_i.scalar[15:0]}};
      ew32:    scalar_rep = {2{insn_i.scalar[31:0]}};
      default: scalar_rep = insn_i.scalar;
    endcase
  end

  assign opa      = insn_i.use_scalar ? scalar_rep : operand_i[0];
  assign lane_w   = 8 << insn_i.vsew;
  assign nr_lanes = (`ELEN / 8) >> insn_i.vsew;

  // vs1 signed only for vmulh, vs2 also for vmulhsu
  assign sgn_a = insn_i.op == op_vmulh;
  assign sgn_b = insn_i.op inside {op_vmulh, op_vmulhsu};

  always_comb begin
    res = '0;
    for (int l = 0; l < `ELEN / 8; l++) begin
      if (l < nr_lanes) begin
        res |= lane_op(opa >> (l * lane_w), operand_i[1] >> (l * lane_w),
                       operand_i[2] >> (l * lane_w), lane_w, insn_i.op,
                       sgn_a, sgn_b) << (l * lane_w);
      end
    end
  end

  // Index 0 is the input side, NumPipeRegs the output
  elen_t [NumPipeRegs:0] result_d;
  strb_t [NumPipeRegs:0] mask_d;
  logic  [NumPipeRegs:0] valid_d;
  logic  [NumPipeRegs:0] stage_ready;

  assign result_d[0] = res;
  assign mask_d[0]   = mask_i;
  assign valid_d[0]  = valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic  valid_q;
    elen_t result_q;
    strb_t mask_q;

    // Stage moves on when downstream accepts or it holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= valid_d[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i]) begin
        result_q <= result_d[i];
        mask_q   <= mask_d[i];
      end
    end

    assign result_d[i+1] = result_q;
    assign mask_d[i+1]   = mask_q;
    assign valid_d[i+1]  = valid_q;
  end

  assign stage_ready[NumPipeRegs] = ready_i;
  assign ready_o  = stage_ready[0];
  assign result_o = result_d[NumPipeRegs];
  assign mask_o   = mask_d[NumPipeRegs];
  assign valid_o  = valid_d[NumPipeRegs];

  // Stalled output holds its word until the result queue takes it
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o) && $stable(mask_o));

endmodule

//--- verilog/result_tagger.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result tagger
// Tracks the instruction being processed and gives each result word its
// id, register file address and byte enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vmul_consts.svh"

module result_tagger (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vmul_pkg::vinsn_t   proc_insn_i,
  input  logic               proc_valid_i,
  input  logic               take_i,
  input  rvv_isa_pkg::strb_t mask_i,
  output vmul_pkg::tag_t     tag_o,
  output logic               proc_done_o
);
  import rvv_isa_pkg::*;
  import vmul_pkg::*;

  // Clear while the head instruction has no word processed yet
  logic  loaded_q;
  vlen_t rem_q;
  vlen_t cur_rem;
  vlen_t rem_left;
  vlen_t done_elems;
  strb_t tail_be;

  assign cur_rem    = loaded_q ? rem_q : proc_insn_i.vl;
  assign rem_left   = elems_left(cur_rem, proc_insn_i.vsew);
  assign done_elems = proc_insn_i.vl - cur_rem;

  // Tail word enables only the bytes of the remaining elements
  assign tail_be = (cur_rem >= elems_per_word(proc_insn_i.vsew)) ? '1 :
                   strb_t'((16'd1 << (cur_rem << proc_insn_i.vsew)) - 16'd1);

  assign tag_o.id   = proc_insn_i.id;
  assign tag_o.addr = vaddr_t'(proc_insn_i.vd * `VREG_WORDS
                               + (done_elems >> (2'd3 - proc_insn_i.vsew)));
  assign tag_o.be   = tail_be & (proc_insn_i.vm ? '1 : mask_i);

  assign proc_done_o = take_i && proc_valid_i && (rem_left == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q <= 1'b0;
      rem_q    <= '0;
    end else if (take_i) begin
      loaded_q <= rem_left != '0;
      rem_q    <= rem_left;
    end
  end

  // Every word leaving the multiplier belongs to a queued instruction
  a_take_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    take_i |-> proc_valid_i);

endmodule

//--- verilog/result_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result queue
// Small FIFO pairing each result word with its tag and driving the
// req/gnt write port toward the register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vmul_consts.svh"

module result_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  rvv_isa_pkg::elen_t  in_data_i,
  input  vmul_pkg::tag_t      tag_i,
  output logic                take_o,
  output logic                result_req_o,
  output vmul_pkg::result_t   result_o,
  input  logic                result_gnt_i,
  output logic                commit_o
);
  import vmul_pkg::*;

  localparam int unsigned PtrW = $clog2(`RESULT_DEPTH);

  // Power-of-two depth, pointers wrap on their own
  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  result_t mem_q [`RESULT_DEPTH];
  ptr_t    wr_ptr_q;
  ptr_t    rd_ptr_q;
  cnt_t    cnt_q;

  assign in_ready_o = cnt_q != cnt_t'(`RESULT_DEPTH);
  // Write strobe, also steps the tagger
  assign take_o     = in_valid_i && in_ready_o;

  // Head entry stays on the port until granted
  assign result_req_o = cnt_q != '0;
  assign result_o     = mem_q[rd_ptr_q];
  assign commit_o     = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + ptr_t'(take_o);
      rd_ptr_q <= rd_ptr_q + ptr_t'(commit_o);
      cnt_q    <= cnt_q + cnt_t'(take_o) - cnt_t'(commit_o);
    end
  end

  // Data and tag merged on entry
  always_ff @(posedge clk_i) begin
    if (take_o) begin
      mem_q[wr_ptr_q] <= '{tag: tag_i, wdata: in_data_i};
    end
  end

  // Register file grants only a pending request
  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o);

endmodule

//--- verilog/vmul_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector integer multiply unit
// Instruction queue and SIMD multiplier feed a tagged result queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vmul_consts.svh"

module vmul_unit (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  vmul_pkg::vinsn_t         vinsn_i,
  input  logic                     vinsn_valid_i,
  output logic                     vinsn_ready_o,
  input  rvv_isa_pkg::elen_t [2:0] operand_i,
  input  logic [2:0]               operand_valid_i,
  output logic [2:0]               operand_ready_o,
  input  rvv_isa_pkg::strb_t       mask_i,
  input  logic                     mask_valid_i,
  output logic                     mask_ready_o,
  output logic                     result_req_o,
  output vmul_pkg::result_t        result_o,
  input  logic                     result_gnt_i,
  output logic [`NR_VINSN-1:0]     done_o
);
  import rvv_isa_pkg::*;
  import vmul_pkg::*;

  // Issue handshake into the multiplier
  logic   issue_valid;
  logic   issue_ready;
  vinsn_t issue_insn;
  // Processing head, seen by the tagger
  vinsn_t proc_insn;
  logic   proc_valid;
  logic   proc_done;
  // Multiplier output toward the result queue
  logic   mul_valid;
  logic   mul_ready;
  elen_t  mul_result;
  strb_t  mul_mask;
  logic   take;
  tag_t   tag;
  logic   commit;

  vinsn_queue vinsn_queue_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .vinsn_i         (vinsn_i),
    .vinsn_valid_i   (vinsn_valid_i),
    .vinsn_ready_o   (vinsn_ready_o),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .issue_valid_o   (issue_valid),
    .issue_ready_i   (issue_ready),
    .issue_insn_o    (issue_insn),
    .proc_insn_o     (proc_insn),
    .proc_valid_o    (proc_valid),
    .proc_done_i     (proc_done),
    .commit_i        (commit),
    .done_o          (done_o)
  );

  simd_mul #(
    .NumPipeRegs (`MUL_PIPE_REGS)
  ) simd_mul_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .insn_i    (issue_insn),
    .operand_i (operand_i),
    .mask_i    (mask_i),
    .valid_i   (issue_valid),
    .ready_o   (issue_ready),
    .valid_o   (mul_valid),
    .result_o  (mul_result),
    .mask_o    (mul_mask),
    .ready_i   (mul_ready)
  );

  result_tagger result_tagger_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .proc_insn_i  (proc_insn),
    .proc_valid_i (proc_valid),
    .take_i       (take),
    .mask_i       (mul_mask),
    .tag_o        (tag),
    .proc_done_o  (proc_done)
  );

  result_queue result_queue_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (mul_valid),
    .in_ready_o   (mul_ready),
    .in_data_i    (mul_result),
    .tag_i        (tag),
    .take_o       (take),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i),
    .commit_o     (commit)
  );

endmodule

//--- bench/vmul_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector multiply unit testbench
// Random operand and grant stimulus, a reference model of the result
// stream and done pulses, checked by concurrent assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vmul_consts.svh"

module vmul_unit_tb;
  import rvv_isa_pkg::*;
  import vmul_pkg::*;

  // Expected word plus a flag for the last word of its instruction
  typedef struct packed {
    result_t res;
    logic    last;
  } exp_word_t;

  logic                 clk_i;
  logic                 rst_ni;
  vinsn_t               vinsn_i;
  logic                 vinsn_valid_i;
  logic                 vinsn_ready_o;
  elen_t [2:0]          operand_i;
  logic [2:0]           operand_valid_i;
  logic [2:0]           operand_ready_o;
  strb_t                mask_i;
  logic                 mask_valid_i;
  logic                 mask_ready_o;
  logic                 result_req_o;
  result_t              result_o;
  logic                 result_gnt_i;
  logic [`NR_VINSN-1:0] done_o;

  // Offered, waiting to issue, and expected on the write port
  vinsn_t    pend_q[$];
  vinsn_t    iss_q[$];
  exp_word_t exp_q[$];
  int        iss_rem;
  int        iss_idx;
  logic      iss_loaded;
  int        held;
  int        acc_cnt[`NR_VINSN];
  int        done_cnt[`NR_VINSN];
  int        next_id;
  logic      gnt_en;
  logic      pop_pending;
  integer    seed;
  int        cycles;

  // Values the assertions compare against, updated mid cycle
  result_t              chk_head;
  logic                 chk_avail;
  logic [`NR_VINSN-1:0] chk_done;
  logic [2:0]           chk_used;
  logic                 chk_vm;
  int                   chk_held;

  vmul_unit vmul_unit_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .vinsn_i         (vinsn_i),
    .vinsn_valid_i   (vinsn_valid_i),
    .vinsn_ready_o   (vinsn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_req_o    (result_req_o),
    .result_o        (result_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string what);
    $display("CHECK FAILED at %0t ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic elen_t lane_mask(int w);
    return (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
  endfunction

  // Scalar copied to every lane
  function automatic elen_t spread_scalar(elen_t s, int w);
    elen_t r;
    r = '0;
    for (int l = 0; l < 64 / w; l++) begin
      r = r | ((s & lane_mask(w)) << (l * w));
    end
    return r;
  endfunction

  // Per-lane RVV integer multiply, 128-bit exact products
  function automatic elen_t ref_word(mul_op_e op, int w, elen_t vs1, elen_t vs2, elen_t vd);
    elen_t        lm;
    elen_t        a;
    elen_t        b;
    elen_t        c;
    elen_t        lane;
    elen_t        word;
    logic [127:0] wa;
    logic [127:0] wb;
    logic [127:0] prod;
    logic         sa;
    logic         sb;
    lm   = lane_mask(w);
    // vmulh signs both factors, vmulhsu only vs2
    sa   = (op == op_vmulh);
    sb   = (op == op_vmulh) || (op == op_vmulhsu);
    word = '0;
    for (int l = 0; l < 64 / w; l++) begin
      a  = (vs1 >> (l * w)) & lm;
      b  = (vs2 >> (l * w)) & lm;
      c  = (vd >> (l * w)) & lm;
      wa = {64'd0, a};
      wb = {64'd0, b};
      if (sa && a[w-1]) wa = wa | ~{64'd0, lm};
      if (sb && b[w-1]) wb = wb | ~{64'd0, lm};
      prod = wa * wb;
      case (op)
        op_vmulh, op_vmulhu, op_vmulhsu: lane = elen_t'(prod >> w);
        op_vmacc:  lane = c + elen_t'(prod);
        op_vnmsac: lane = c - elen_t'(prod);
        default:   lane = elen_t'(prod);
      endcase
      word = word | ((lane & lm) << (l * w));
    end
    return word;
  endfunction

  task automatic add_insn(input mul_op_e op, input vew_e ew, input int vl, input int vd,
                          input logic vm, input logic use_scalar);
    vinsn_t v;
    v.id         = vid_t'(next_id % `NR_VINSN);
    v.op         = op;
    v.vsew       = ew;
    v.vl         = vlen_t'(vl);
    v.vd         = vreg_t'(vd);
    v.vm         = vm;
    v.use_scalar = use_scalar;
    v.use_vs1    = !use_scalar;
    v.use_vs2    = 1'b1;
    v.use_vd     = (op == op_vmacc) || (op == op_vnmsac);
    v.scalar     = {$random(seed), $random(seed)};
    next_id++;
    pend_q.push_back(v);
  endtask

  task automatic drive_inputs();
    vinsn_valid_i = (pend_q.size() != 0) && (rand_below(4) != 0);
    if (pend_q.size() != 0) vinsn_i = pend_q[0];
    for (int k = 0; k < 3; k++) begin
      operand_i[k]       = {$random(seed), $random(seed)};
      operand_valid_i[k] = rand_below(4) != 0;
    end
    mask_i       = strb_t'($random(seed));
    mask_valid_i = rand_below(4) != 0;
    // Grant only a pending request
    result_gnt_i = gnt_en && result_req_o && (rand_below(4) != 0);
  endtask

  // Mid-cycle bookkeeping while every DUT output is settled
  task automatic observe();
    vinsn_t    insn;
    exp_word_t e;
    elen_t     vs1;
    int        w;
    int        epw;
    int        nb;
    if (pop_pending) void'(exp_q.pop_front());
    pop_pending = result_req_o && result_gnt_i;
    chk_avail   = exp_q.size() != 0;
    chk_head    = chk_avail ? exp_q[0].res : '0;
    chk_done    = '0;
    if (pop_pending && chk_avail && exp_q[0].last) chk_done[exp_q[0].res.tag.id] = 1'b1;
    chk_used = '0;
    chk_vm   = 1'b1;
    if (iss_q.size() != 0) begin
      chk_used = {iss_q[0].use_vd, iss_q[0].use_vs2, iss_q[0].use_vs1};
      chk_vm   = iss_q[0].vm;
    end
    chk_held = held;
    // Issued word, predicted from the operands on the bus
    if (operand_ready_o != '0) begin
      if (iss_q.size() == 0) report_mismatch("operand acknowledged with nothing to issue");
      insn = iss_q[0];
      if (!iss_loaded) begin
        iss_rem    = int'(insn.vl);
        iss_idx    = 0;
        iss_loaded = 1'b1;
      end
      w   = 8 << int'(insn.vsew);
      epw = 64 / w;
      vs1 = insn.use_scalar ? spread_scalar(insn.scalar, w) : operand_i[0];
      nb  = ((iss_rem < epw) ? iss_rem : epw) * (w / 8);
      e.res.wdata    = ref_word(insn.op, w, vs1, operand_i[1], operand_i[2]);
      e.res.tag.id   = insn.id;
      e.res.tag.addr = vaddr_t'(int'(insn.vd) * `VREG_WORDS + iss_idx);
      for (int b = 0; b < 8; b++) begin
        e.res.tag.be[b] = (b < nb) && (insn.vm || mask_i[b]);
      end
      e.last = iss_rem <= epw;
      exp_q.push_back(e);
      iss_rem = iss_rem - epw;
      iss_idx++;
      if (e.last) begin
        void'(iss_q.pop_front());
        iss_loaded = 1'b0;
      end
    end
    if (vinsn_valid_i && vinsn_ready_o) begin
      iss_q.push_back(vinsn_i);
      acc_cnt[vinsn_i.id]++;
      held++;
      void'(pend_q.pop_front());
    end
    for (int i = 0; i < `NR_VINSN; i++) begin
      if (done_o[i]) begin
        done_cnt[i]++;
        held--;
      end
    end
  endtask

  task automatic step_cycle();
    @(negedge clk_i);
    drive_inputs();
    #10;
    observe();
  endtask

  a_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && result_gnt_i) |-> (chk_avail && result_o == chk_head))
    else report_mismatch($sformatf("granted %h, expected %h", result_o, chk_head));

  // Ungranted request keeps its word on the port
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && !result_gnt_i) |=> (result_req_o && $stable(result_o)))
    else report_mismatch("result request dropped or changed before its grant");

  a_done: assert property (@(posedge clk_i) disable iff (!rst_ni) done_o == chk_done)
    else report_mismatch($sformatf("done_o %b, expected %b", done_o, chk_done));

  a_operands: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_ready_o != '0) |-> operand_ready_o == chk_used)
    else report_mismatch($sformatf("operand_ready_o %b, expected %b", operand_ready_o, chk_used));

  a_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mask_ready_o == ((operand_ready_o != '0) && !chk_vm))
    else report_mismatch("mask_ready_o does not follow the masked issue");

  a_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vinsn_ready_o == (chk_held < `VINSN_DEPTH))
    else report_mismatch($sformatf("vinsn_ready_o %b with %0d held", vinsn_ready_o, chk_held));

  initial begin
    seed            = 32'h5cbf;
    rst_ni          = 1'b0;
    vinsn_i         = '0;
    vinsn_valid_i   = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    iss_rem         = 0;
    iss_idx         = 0;
    iss_loaded      = 1'b0;
    held            = 0;
    next_id         = 0;
    gnt_en          = 1'b0;
    pop_pending     = 1'b0;
    chk_head        = '0;
    chk_avail       = 1'b0;
    chk_done        = '0;
    chk_used        = '0;
    chk_vm          = 1'b1;
    chk_held        = 0;
    for (int i = 0; i < `NR_VINSN; i++) begin
      acc_cnt[i]  = 0;
      done_cnt[i] = 0;
    end
    // Widths with tail words, then high halves, accumulate, scalar, masked
    add_insn(op_vmul, ew8, 20, 2, 1'b1, 1'b0);
    add_insn(op_vmul, ew16, 10, 3, 1'b1, 1'b0);
    add_insn(op_vmul, ew32, 5, 4, 1'b1, 1'b0);
    add_insn(op_vmul, ew64, 3, 5, 1'b1, 1'b0);
    add_insn(op_vmulh, ew8, 13, 6, 1'b1, 1'b0);
    add_insn(op_vmulhu, ew16, 7, 7, 1'b1, 1'b0);
    add_insn(op_vmulhsu, ew32, 4, 8, 1'b1, 1'b0);
    add_insn(op_vmulh, ew64, 2, 9, 1'b1, 1'b0);
    add_insn(op_vmulhu, ew64, 2, 10, 1'b1, 1'b0);
    add_insn(op_vmulhsu, ew64, 2, 11, 1'b1, 1'b0);
    add_insn(op_vmacc, ew8, 9, 12, 1'b1, 1'b0);
    add_insn(op_vnmsac, ew32, 3, 13, 1'b1, 1'b0);
    add_insn(op_vmacc, ew64, 2, 14, 1'b1, 1'b0);
    add_insn(op_vmul, ew8, 16, 15, 1'b1, 1'b1);
    add_insn(op_vmulhsu, ew16, 6, 16, 1'b1, 1'b1);
    add_insn(op_vmacc, ew32, 5, 17, 1'b1, 1'b1);
    add_insn(op_vmul, ew8, 11, 18, 1'b0, 1'b0);
    add_insn(op_vnmsac, ew16, 6, 31, 1'b0, 1'b1);
    for (int n = 0; n < 12; n++) begin
      add_insn(mul_op_e'(rand_below(6)), vew_e'(rand_below(4)), 0, int'(rand_below(32)),
               rand_below(3) != 0, rand_below(3) == 0);
      // Length up to one register of the chosen width
      pend_q[pend_q.size()-1].vl = vlen_t'(1 + rand_below(64 >> pend_q[pend_q.size()-1].vsew));
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #10;
    assert (vinsn_ready_o && operand_ready_o == '0 && !mask_ready_o && !result_req_o
            && done_o == '0)
      else report_mismatch("outputs not idle after reset");
    // Grant held low until the instruction queue is full
    cycles = 0;
    while (held < `VINSN_DEPTH && cycles < 200) begin
      step_cycle();
      cycles++;
    end
    if (held < `VINSN_DEPTH) abort_on_timeout("four instructions to be accepted");
    repeat (10) step_cycle();
    assert (!vinsn_ready_o) else report_mismatch("vinsn_ready_o high with a full queue");
    gnt_en = 1'b1;
    cycles = 0;
    while (pend_q.size() != 0 && cycles < 4000) begin
      step_cycle();
      cycles++;
    end
    if (pend_q.size() != 0) abort_on_timeout("the remaining instructions to be accepted");
    cycles = 0;
    while ((iss_q.size() != 0 || exp_q.size() != 0 || held != 0) && cycles < 2000) begin
      step_cycle();
      cycles++;
    end
    if (held != 0) abort_on_timeout("the last results and done pulses");
    if (exp_q.size() != 0) abort_on_timeout("the last result words to be granted");
    for (int i = 0; i < `NR_VINSN; i++) begin
      assert (done_cnt[i] == acc_cnt[i])
        else report_mismatch($sformatf("id %0d done %0d times, accepted %0d times", i,
                                       done_cnt[i], acc_cnt[i]));
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+verilog
verilog/rvv_isa_pkg.sv
verilog/vmul_pkg.sv
verilog/vinsn_queue.sv
verilog/simd_mul.sv
verilog/result_tagger.sv
verilog/result_queue.sv
verilog/vmul_unit.sv
bench/vmul_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the vmul_unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f flist.f --top-module vmul_unit_tb \
  --Mdir obj_dir -o vmul_unit_sim &&
  out=$(./obj_dir/vmul_unit_sim 2>&1; true) &&
  echo "$out" &&
  echo "$out" | grep -q "SIMULATION PASSED" &&
  echo "run_sim: pass" ||
  { echo "run_sim: fail"; exit 1; }
exit 0
